// File: logic/vec_cfg.svh
// Vector unit configuration
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

////////////////////
// Lanes
////////////////////

// Number of parallel lanes, must be a power of two
`define VEC_NR_LANES 4

////////////////////
// Register file
////////////////////

// Architectural vector registers
`define VEC_NR_VREGS 8
// Element width in bits
`define VEC_ELEN 16

`endif

// File: logic/vec_isa_pkg.sv
// Vector instruction encoding
`include "vec_cfg.svh"

package vec_isa_pkg;

  // Opcodes carried in the top nibble of every instruction
  typedef enum logic [3:0] {
    VADD_VV    = 4'h0,
    VSUB_VV    = 4'h1,
    VAND_VV    = 4'h2,
    VXOR_VV    = 4'h3,
    VID_V      = 4'h4,
    VADD_VX    = 4'h5,
    VMV_VX     = 4'h6,
    VREDSUM_VS = 4'h7
  } vop_e;

  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [`VEC_ELEN-1:0]             elem_t;

  // Vector-vector format
  typedef struct packed {
    vop_e        op;
    vreg_idx_t   vd;
    vreg_idx_t   vs2;
    vreg_idx_t   vs1;
    logic [18:0] pad;
  } insn_vv_t;

  // Vector-scalar format, scalar replaces vs1
  typedef struct packed {
    vop_e                        op;
    vreg_idx_t                   vd;
    vreg_idx_t                   vs2;
    elem_t                       scalar;
    logic [31-10-`VEC_ELEN:0]    pad;
  } insn_vx_t;

  // Same 32-bit word, opcode picks the view
  typedef union packed {
    insn_vv_t vv;
    insn_vx_t vx;
  } vec_insn_u;

endpackage

// File: logic/vec_xfer_pkg.sv
// Lane operation and response types
package vec_xfer_pkg;

  ////////////////////
  // Issue side
  ////////////////////

  // Decoded operation broadcast to every lane
  typedef struct packed {
    vec_isa_pkg::vop_e      op;
    vec_isa_pkg::vreg_idx_t vd;
    vec_isa_pkg::vreg_idx_t vs1;
    vec_isa_pkg::vreg_idx_t vs2;
    vec_isa_pkg::elem_t     scalar;
  } lane_op_t;

  ////////////////////
  // Completion side
  ////////////////////

  // Scalar completion returned to the core
  typedef struct packed {
    vec_isa_pkg::vop_e  op;
    vec_isa_pkg::elem_t result;
  } vec_rsp_t;

endpackage

// File: logic/vec_dispatcher.sv
// Vector command dispatcher
`timescale 1ns/100ps

module vec_dispatcher import vec_isa_pkg::*, vec_xfer_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Command port from the core
  input  logic      cmd_req_i,
  input  vec_insn_u cmd_insn_i,
  output logic      cmd_ack_o,
  // Completion from the responder
  input  logic      rsp_done_i,
  // Broadcast to the lanes
  output lane_op_t  lane_op_o,
  output logic      lane_op_valid_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACKED,
    ST_BUSY
  } disp_state_e;

  disp_state_e state_q;
  logic        done_seen_q;
  vop_e        op;
  lane_op_t    lane_op_d;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    op            = cmd_insn_i.vv.op;
    lane_op_d.op  = op;
    lane_op_d.vd  = cmd_insn_i.vv.vd;
    lane_op_d.vs2 = cmd_insn_i.vv.vs2;
    // Scalar forms carry an immediate where vs1 would be
    if (op == VADD_VX || op == VMV_VX) begin
      lane_op_d.vs1    = '0;
      lane_op_d.scalar = cmd_insn_i.vx.scalar;
    end else begin
      lane_op_d.vs1    = cmd_insn_i.vv.vs1;
      lane_op_d.scalar = '0;
    end
  end

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q         <= ST_IDLE;
      cmd_ack_o       <= 1'b0;
      lane_op_valid_o <= 1'b0;
      done_seen_q     <= 1'b0;
    end else begin
      lane_op_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (cmd_req_i) begin
            cmd_ack_o       <= 1'b1;
            lane_op_valid_o <= 1'b1;
            done_seen_q     <= 1'b0;
            state_q         <= ST_ACKED;
          end
        end
        ST_ACKED: begin
          // Response may close before the core drops its request
          if (rsp_done_i) begin
            done_seen_q <= 1'b1;
          end
          if (!cmd_req_i) begin
            cmd_ack_o <= 1'b0;
            state_q   <= (rsp_done_i || done_seen_q) ? ST_IDLE : ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (rsp_done_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Operation held until the next accepted command
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && cmd_req_i) begin
      lane_op_o <= lane_op_d;
    end
  end

endmodule

// File: logic/vec_lane.sv
// Vector lane with integer ALU
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_lane import vec_isa_pkg::*, vec_xfer_pkg::*; (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // Position of this lane in the array
  input  logic [$clog2(`VEC_NR_LANES)-1:0] lane_idx_i,
  // Broadcast operation
  input  lane_op_t                         lane_op_i,
  input  logic                             lane_op_valid_i,
  // Element result
  output elem_t                            lane_res_o,
  output logic                             lane_res_valid_o
);

  // One element of every vector register
  elem_t vrf_q [`VEC_NR_VREGS];
  elem_t src1;
  elem_t src2;
  elem_t alu_res;

  ////////////////////
  // ALU
  ////////////////////

  assign src1 = vrf_q[lane_op_i.vs1];
  assign src2 = vrf_q[lane_op_i.vs2];

  always_comb begin
    case (lane_op_i.op)
      VADD_VV: alu_res = src2 + src1;
      VSUB_VV: alu_res = src2 - src1;
      VAND_VV: alu_res = src2 & src1;
      VXOR_VV: alu_res = src2 ^ src1;
      VID_V:   alu_res = elem_t'(lane_idx_i);
      VADD_VX: alu_res = src2 + lane_op_i.scalar;
      VMV_VX:  alu_res = lane_op_i.scalar;
      // Reduction forwards vs2 to the responder
      default: alu_res = src2;
    endcase
  end

  ////////////////////
  // Register slice
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `VEC_NR_VREGS; i++) begin
        vrf_q[i] <= '0;
      end
    end else if (lane_op_valid_i && lane_op_i.op != VREDSUM_VS) begin
      vrf_q[lane_op_i.vd] <= alu_res;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lane_res_valid_o <= 1'b0;
    end else begin
      lane_res_valid_o <= lane_op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_op_valid_i) begin
      lane_res_o <= alu_res;
    end
  end

endmodule

// File: logic/vec_reduce_resp.sv
// Reduction and response port
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_reduce_resp import vec_isa_pkg::*, vec_xfer_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Issued operation
  input  lane_op_t                 lane_op_i,
  input  logic                     lane_op_valid_i,
  // Lane elements
  input  elem_t [`VEC_NR_LANES-1:0] lane_res_i,
  input  logic                     lane_res_valid_i,
  // Response port to the core
  output vec_rsp_t                 rsp_o,
  output logic                     rsp_req_o,
  input  logic                     rsp_ack_i,
  // Handshake closed
  output logic                     rsp_done_o
);

  typedef enum logic [1:0] {
    RSP_IDLE,
    RSP_REQ,
    RSP_DROP
  } rsp_state_e;

  rsp_state_e state_q;
  vop_e       op_q;
  elem_t      lane_sum;
  vec_rsp_t   rsp_d;

  always_ff @(posedge clk_i) begin
    if (lane_op_valid_i) begin
      op_q <= lane_op_i.op;
    end
  end

  ////////////////////
  // Reduction
  ////////////////////

  // Wraps modulo 2^ELEN
  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      lane_sum = lane_sum + lane_res_i[i];
    end
  end

  always_comb begin
    rsp_d.op     = op_q;
    rsp_d.result = (op_q == VREDSUM_VS) ? lane_sum : lane_res_i[0];
  end

  ////////////////////
  // Response FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= RSP_IDLE;
      rsp_req_o  <= 1'b0;
      rsp_done_o <= 1'b0;
    end else begin
      rsp_done_o <= 1'b0;
      case (state_q)
        RSP_IDLE: begin
          if (lane_res_valid_i) begin
            rsp_req_o <= 1'b1;
            state_q   <= RSP_REQ;
          end
        end
        RSP_REQ: begin
          if (rsp_ack_i) begin
            rsp_req_o <= 1'b0;
            state_q   <= RSP_DROP;
          end
        end
        RSP_DROP: begin
          if (!rsp_ack_i) begin
            rsp_done_o <= 1'b1;
            state_q    <= RSP_IDLE;
          end
        end
        default: state_q <= RSP_IDLE;
      endcase
    end
  end

  // Data frozen for the whole handshake
  always_ff @(posedge clk_i) begin
    if (state_q == RSP_IDLE && lane_res_valid_i) begin
      rsp_o <= rsp_d;
    end
  end

endmodule

// File: logic/vec_top.sv
// Vector coprocessor top level
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_top import vec_isa_pkg::*, vec_xfer_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Command port
  input  logic      cmd_req_i,
  input  vec_insn_u cmd_insn_i,
  output logic      cmd_ack_o,
  // Response port
  output vec_rsp_t  rsp_o,
  output logic      rsp_req_o,
  input  logic      rsp_ack_i
);

  lane_op_t                   lane_op;
  logic                       lane_op_valid;
  elem_t [`VEC_NR_LANES-1:0]  lane_res;
  logic  [`VEC_NR_LANES-1:0]  lane_res_valid;
  logic                       rsp_done;

  ////////////////////
  // Dispatcher
  ////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i          (clk_i        ),
    .reset_i        (reset_i      ),
    .cmd_req_i      (cmd_req_i    ),
    .cmd_insn_i     (cmd_insn_i   ),
    .cmd_ack_o      (cmd_ack_o    ),
    .rsp_done_i     (rsp_done     ),
    .lane_op_o      (lane_op      ),
    .lane_op_valid_o(lane_op_valid)
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar lane = 0; lane < `VEC_NR_LANES; lane++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i           (clk_i                                 ),
      .reset_i         (reset_i                               ),
      .lane_idx_i      (($clog2(`VEC_NR_LANES))'(lane)        ),
      .lane_op_i       (lane_op                               ),
      .lane_op_valid_i (lane_op_valid                         ),
      .lane_res_o      (lane_res[lane]                        ),
      .lane_res_valid_o(lane_res_valid[lane]                  )
    );
  end : gen_lanes

  ////////////////////
  // Responder
  ////////////////////

  // All lanes finish together
  vec_reduce_resp i_reduce_resp (
    .clk_i           (clk_i          ),
    .reset_i         (reset_i        ),
    .lane_op_i       (lane_op        ),
    .lane_op_valid_i (lane_op_valid  ),
    .lane_res_i      (lane_res       ),
    .lane_res_valid_i(&lane_res_valid),
    .rsp_o           (rsp_o          ),
    .rsp_req_o       (rsp_req_o      ),
    .rsp_ack_i       (rsp_ack_i      ),
    .rsp_done_o      (rsp_done       )
  );

endmodule

// File: tests/vec_top_asserts.sv
// Handshake protocol checks
`timescale 1ns/100ps

module vec_top_asserts import vec_xfer_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input logic     cmd_req_i,
  input logic     cmd_ack_o,
  input vec_rsp_t rsp_o,
  input logic     rsp_req_o,
  input logic     rsp_ack_i
);

  ////////////////////
  // Command port
  ////////////////////

  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cmd_ack_o) |-> $past(cmd_req_i))
    else $error("cmd_ack_o rose without a pending cmd_req_i");

  // One instruction in flight
  ack_not_during_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cmd_ack_o) |-> !$past(rsp_req_o))
    else $error("cmd_ack_o rose while a response was still pending");

  ////////////////////
  // Response port
  ////////////////////

  rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (rsp_req_o && $past(rsp_req_o)) |-> $stable(rsp_o))
    else $error("rsp_o changed while rsp_req_o was high");

  rsp_drop_after_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(rsp_req_o) |-> $past(rsp_ack_i))
    else $error("rsp_req_o dropped before rsp_ack_i was seen");

  // Fixed issue to response latency
  rsp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    ($past(cmd_ack_o, 2) && !$past(cmd_ack_o, 3)) |-> $rose(rsp_req_o))
    else $error("rsp_req_o did not rise two cycles after cmd_ack_o");

endmodule

bind vec_top vec_top_asserts i_asserts (
  .clk_i    (clk_i    ),
  .reset_i  (reset_i  ),
  .cmd_req_i(cmd_req_i),
  .cmd_ack_o(cmd_ack_o),
  .rsp_o    (rsp_o    ),
  .rsp_req_o(rsp_req_o),
  .rsp_ack_i(rsp_ack_i)
);

// File: tests/vec_top_tb.sv
// Vector coprocessor testbench
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_top_tb import vec_isa_pkg::*, vec_xfer_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int HOLD_CYCLES    = 25;

  logic      clk;
  logic      reset;
  logic      cmd_req;
  vec_insn_u cmd_insn;
  logic      cmd_ack;
  vec_rsp_t  rsp;
  logic      rsp_req;
  logic      rsp_ack;

  // Expected responses in issue order
  vec_rsp_t    exp_mem [64];
  logic [5:0]  exp_head;
  logic [5:0]  exp_tail;
  vec_rsp_t    exp_rsp;
  logic [15:0] lfsr_state;
  int          error_count;
  int          test_count;
  int          rsp_count;

  assign exp_rsp = exp_mem[exp_head];

  vec_top uut (
    .clk_i     (clk     ),
    .reset_i   (reset   ),
    .cmd_req_i (cmd_req ),
    .cmd_insn_i(cmd_insn),
    .cmd_ack_o (cmd_ack ),
    .rsp_o     (rsp     ),
    .rsp_req_o (rsp_req ),
    .rsp_ack_i (rsp_ack )
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////
  // Checks
  ////////////////////

  assert property (@(posedge clk) $fell(reset) |-> (!cmd_ack && !rsp_req))
    else begin
      $display("FAILED at %0t: cmd_ack_o or rsp_req_o high after reset", $time);
      error_count++;
    end

  assert property (@(posedge clk) disable iff (reset) rsp_req |-> (rsp == exp_rsp))
    else begin
      $display("FAILED at %0t: response op %0h result %0h, expected op %0h result %0h",
               $time, rsp.op, rsp.result, exp_rsp.op, exp_rsp.result);
      error_count++;
    end

  // Next command only after the response handshake closed
  assert property (@(posedge clk) disable iff (reset)
    $rose(cmd_ack) |-> (!$past(rsp_req) && !$past(rsp_ack)))
    else begin
      $display("FAILED at %0t: command accepted before the response closed", $time);
      error_count++;
    end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit
  function automatic logic [15:0] random_bits(input int width);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic vec_insn_u vv_insn(input vop_e op, input vreg_idx_t vd,
                                        input vreg_idx_t vs2, input vreg_idx_t vs1);
    vec_insn_u insn;
    insn        = '0;
    insn.vv.op  = op;
    insn.vv.vd  = vd;
    insn.vv.vs2 = vs2;
    insn.vv.vs1 = vs1;
    return insn;
  endfunction

  function automatic vec_insn_u vx_insn(input vop_e op, input vreg_idx_t vd,
                                        input vreg_idx_t vs2, input elem_t scalar);
    vec_insn_u insn;
    insn           = '0;
    insn.vx.op     = op;
    insn.vx.vd     = vd;
    insn.vx.vs2    = vs2;
    insn.vx.scalar = scalar;
    return insn;
  endfunction

  function automatic elem_t times_lanes(input elem_t x);
    return elem_t'(`VEC_NR_LANES) * x;
  endfunction

  // Element result of a vv op on the vs2 and vs1 values
  function automatic elem_t vv_result(input vop_e op, input elem_t x, input elem_t y);
    case (op)
      VADD_VV: return x + y;
      VSUB_VV: return x - y;
      VAND_VV: return x & y;
      VXOR_VV: return x ^ y;
      default: return '0;
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic push_expected(input vop_e op, input elem_t result);
    vec_rsp_t entry;
    entry.op           = op;
    entry.result       = result;
    exp_mem[exp_tail]  = entry;
    exp_tail           = exp_tail + 6'd1;
  endtask

  task automatic drive_command(input vec_insn_u insn);
    @(negedge clk);
    cmd_insn = insn;
    cmd_req  = 1'b1;
  endtask

  task automatic finish_command();
    int cycles;
    cycles = 0;
    while (!cmd_ack && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_ack) abort_run("cmd_ack_o to rise");
    cmd_req = 1'b0;
    cycles  = 0;
    while (cmd_ack && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_ack) abort_run("cmd_ack_o to fall");
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    while (!rsp_req && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!rsp_req) abort_run("rsp_req_o to rise");
  endtask

  task automatic accept_response();
    int cycles;
    cycles  = 0;
    rsp_ack = 1'b1;
    while (rsp_req && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (rsp_req) abort_run("rsp_req_o to fall");
    exp_head = exp_head + 6'd1;
    rsp_count++;
    rsp_ack = 1'b0;
  endtask

  task automatic run_insn(input vec_insn_u insn, input vop_e op, input elem_t result);
    push_expected(op, result);
    drive_command(insn);
    finish_command();
    wait_response();
    accept_response();
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d (%s) finished, errors so far %0d", test_count, name, error_count);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    elem_t a;
    elem_t b;
    elem_t s;
    elem_t acc;
    vop_e  vv_ops [4];
    cmd_req     = 1'b0;
    cmd_insn    = '0;
    rsp_ack     = 1'b0;
    reset       = 1'b1;
    exp_head    = '0;
    exp_tail    = '0;
    lfsr_state  = 16'd30;
    error_count = 0;
    test_count  = 0;
    rsp_count   = 0;
    vv_ops      = '{VADD_VV, VSUB_VV, VAND_VV, VXOR_VV};
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Registers start cleared
    run_insn(vv_insn(VREDSUM_VS, '0, vreg_idx_t'(random_bits(3)), '0), VREDSUM_VS, '0);
    end_test("reset state");

    s = random_bits(16);
    run_insn(vx_insn(VMV_VX, 3'd2, '0, s), VMV_VX, s);
    run_insn(vv_insn(VREDSUM_VS, '0, 3'd2, '0), VREDSUM_VS, times_lanes(s));
    end_test("scalar broadcast");

    acc = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      acc = acc + elem_t'(i);
    end
    run_insn(vv_insn(VID_V, 3'd3, '0, '0), VID_V, '0);
    run_insn(vv_insn(VREDSUM_VS, '0, 3'd3, '0), VREDSUM_VS, acc);
    s = random_bits(16);
    run_insn(vx_insn(VADD_VX, 3'd4, 3'd3, s), VADD_VX, s);
    run_insn(vv_insn(VREDSUM_VS, '0, 3'd4, '0), VREDSUM_VS, acc + times_lanes(s));
    end_test("lane index and scalar add");

    a = random_bits(16);
    b = random_bits(16);
    run_insn(vx_insn(VMV_VX, 3'd1, '0, a), VMV_VX, a);
    run_insn(vx_insn(VMV_VX, 3'd2, '0, b), VMV_VX, b);
    for (int i = 0; i < 4; i++) begin
      s = vv_result(vv_ops[i], a, b);
      run_insn(vv_insn(vv_ops[i], 3'd5, 3'd1, 3'd2), vv_ops[i], s);
      run_insn(vv_insn(VREDSUM_VS, '0, 3'd5, '0), VREDSUM_VS, times_lanes(s));
    end
    // Lane index mixed with a broadcast value
    acc = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      acc = acc + (elem_t'(i) ^ a);
    end
    run_insn(vv_insn(VXOR_VV, 3'd6, 3'd3, 3'd1), VXOR_VV, a);
    run_insn(vv_insn(VREDSUM_VS, '0, 3'd6, '0), VREDSUM_VS, acc);
    end_test("vector-vector ops");

    s = random_bits(16);
    push_expected(VMV_VX, s);
    drive_command(vx_insn(VMV_VX, 3'd7, '0, s));
    finish_command();
    wait_response();
    // Next request raised while the response is held
    push_expected(VREDSUM_VS, times_lanes(s));
    drive_command(vv_insn(VREDSUM_VS, '0, 3'd7, '0));
    repeat (HOLD_CYCLES) @(negedge clk);
    accept_response();
    finish_command();
    wait_response();
    accept_response();
    end_test("back-pressure");

    repeat (4) @(negedge clk);
    $display("Summary: %0d tests, %0d responses, %0d errors",
             test_count, rsp_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+logic
logic/vec_isa_pkg.sv
logic/vec_xfer_pkg.sv
logic/vec_dispatcher.sv
logic/vec_lane.sv
logic/vec_reduce_resp.sv
logic/vec_top.sv
tests/vec_top_asserts.sv
tests/vec_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module vec_top_tb \
  -f filelist.f \
  -o vec_top_sim

./obj_dir/vec_top_sim 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
